// ==== hw/axi_sys_pkg.sv ====
// Shared widths, codes and register map of the AXI to system bus bridge.
// Single-beat 32-bit accesses only; the timeout assumes a slave acking well under 32 cycles.
package axi_sys_pkg;

  // ------------------------------
  // bus widths
  // ------------------------------
  localparam int AXI_AW = 32;  // address, AXI and system side
  localparam int AXI_DW = 32;
  localparam int AXI_IW = 12;  // transaction id
  localparam int AXI_LW = 4;   // AXI3 burst length field
  localparam int AXI_ZW = 3;   // size field
  localparam int AXI_SW = AXI_DW / 8;  // byte strobes and sys_sel

  localparam logic [AXI_ZW-1:0] AXI_SIZE_WORD = 3'd2;  // 4 bytes per beat

  // acknowledge wait limit
  localparam int ACK_TIMEOUT = 32;
  localparam int ACK_CNT_W   = $clog2(ACK_TIMEOUT);

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_REQ,
    ST_RD_REQ,
    ST_WAIT_ACK,
    ST_WR_RESP,
    ST_RD_RESP
  } bridge_state_e;

  // ------------------------------
  // register bank map
  // ------------------------------
  localparam logic [9:0] REG_A_OFS  = 10'h000;
  localparam logic [9:0] REG_B_OFS  = 10'h004;
  localparam logic [9:0] REG_C_OFS  = 10'h008;
  localparam logic [9:0] REG_ID_OFS = 10'h00c;

  localparam logic [AXI_DW-1:0] REG_B_RST  = 32'h1234_5678;
  localparam logic [AXI_DW-1:0] REG_C_RST  = 32'h0000_0505;
  localparam logic [AXI_DW-1:0] REG_ID_VAL = 32'h0b1d_0001;

  localparam int REG_B_ACK_DLY = 3;  // cycles from pulse to ack

endpackage

// ==== hw/axi_req_fsm.sv ====
// Bridge control FSM. One transaction in flight; write and read alternate when both wait.
// AW and W must be presented together, a lone AW or W is never accepted.
`timescale 1ns/1ps

module axi_req_fsm (
  input  logic                  axi_aclk,
  input  logic                  sys_rstn,
  input  logic                  awvalid_i,
  input  logic                  wvalid_i,
  input  logic                  arvalid_i,
  input  logic                  bready_i,
  input  logic                  rready_i,
  input  logic                  size_ok_i,
  input  logic                  len_zero_i,
  input  logic                  sys_ack_i,
  input  logic                  sys_err_i,
  input  logic                  timeout_i,
  output logic                  awready_o,
  output logic                  wready_o,
  output logic                  arready_o,
  output logic                  bvalid_o,
  output logic                  rvalid_o,
  output logic                  capture_wr_o,
  output logic                  capture_rd_o,
  output logic                  issue_wen_o,
  output logic                  issue_ren_o,
  output logic                  timer_start_o,
  output logic                  resp_load_o,
  output axi_sys_pkg::resp_e    resp_sel_o
);

  axi_sys_pkg::bridge_state_e state_q, state_d;
  axi_sys_pkg::bridge_state_e resp_st;
  logic last_wr_q;  // 1 when the current or last access is a write
  logic take_wr;
  logic take_rd;

  // alternate priority when both request types are pending
  assign take_wr = awvalid_i && wvalid_i && (!arvalid_i || !last_wr_q);
  assign take_rd = arvalid_i && !take_wr;
  assign resp_st = last_wr_q ? axi_sys_pkg::ST_WR_RESP : axi_sys_pkg::ST_RD_RESP;

  always_comb begin
    state_d       = state_q;
    awready_o     = 1'b0;
    wready_o      = 1'b0;
    arready_o     = 1'b0;
    bvalid_o      = 1'b0;
    rvalid_o      = 1'b0;
    capture_wr_o  = 1'b0;
    capture_rd_o  = 1'b0;
    issue_wen_o   = 1'b0;
    issue_ren_o   = 1'b0;
    timer_start_o = 1'b0;
    resp_load_o   = 1'b0;
    resp_sel_o    = axi_sys_pkg::RESP_OKAY;
    case (state_q)
      axi_sys_pkg::ST_IDLE: begin
        awready_o    = take_wr;
        wready_o     = take_wr;
        arready_o    = take_rd;
        capture_wr_o = take_wr;
        capture_rd_o = take_rd;
        if (take_wr) state_d = axi_sys_pkg::ST_WR_REQ;
        else if (take_rd) state_d = axi_sys_pkg::ST_RD_REQ;
      end
      axi_sys_pkg::ST_WR_REQ, axi_sys_pkg::ST_RD_REQ: begin
        if (!size_ok_i) begin  // bad size, no bus cycle
          resp_load_o = 1'b1;
          resp_sel_o  = axi_sys_pkg::RESP_SLVERR;
          state_d     = resp_st;
        end else begin
          issue_wen_o   = (state_q == axi_sys_pkg::ST_WR_REQ);
          issue_ren_o   = (state_q == axi_sys_pkg::ST_RD_REQ);
          timer_start_o = 1'b1;
          if (sys_ack_i) begin  // same-cycle ack
            resp_load_o = 1'b1;
            resp_sel_o  = sys_err_i ? axi_sys_pkg::RESP_SLVERR : axi_sys_pkg::RESP_OKAY;
            state_d     = resp_st;
          end else begin
            state_d = axi_sys_pkg::ST_WAIT_ACK;
          end
        end
      end
      axi_sys_pkg::ST_WAIT_ACK: begin
        if (sys_ack_i) begin
          resp_load_o = 1'b1;
          resp_sel_o  = sys_err_i ? axi_sys_pkg::RESP_SLVERR : axi_sys_pkg::RESP_OKAY;
          state_d     = resp_st;
        end else if (timeout_i) begin  // nobody answered
          resp_load_o = 1'b1;
          resp_sel_o  = axi_sys_pkg::RESP_DECERR;
          state_d     = resp_st;
        end
      end
      axi_sys_pkg::ST_WR_RESP: begin
        bvalid_o = 1'b1;
        if (bready_i) state_d = axi_sys_pkg::ST_IDLE;
      end
      axi_sys_pkg::ST_RD_RESP: begin
        rvalid_o = 1'b1;
        if (rready_i) state_d = axi_sys_pkg::ST_IDLE;
      end
      default: state_d = axi_sys_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge axi_aclk) begin
    if (!sys_rstn) begin
      state_q   <= axi_sys_pkg::ST_IDLE;
      last_wr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (capture_wr_o) last_wr_q <= 1'b1;
      else if (capture_rd_o) last_wr_q <= 1'b0;
    end
  end

  // response held under back-pressure, nothing new taken meanwhile
  a_b_hold: assert property (@(posedge axi_aclk) disable iff (!sys_rstn)
    (bvalid_o && !bready_i) |=> (bvalid_o && !capture_wr_o && !capture_rd_o));
  a_r_hold: assert property (@(posedge axi_aclk) disable iff (!sys_rstn)
    (rvalid_o && !rready_i) |=> (rvalid_o && !capture_wr_o && !capture_rd_o));
  a_one_cmd: assert property (@(posedge axi_aclk) disable iff (!sys_rstn)
    !(issue_wen_o && issue_ren_o));
  // bursts are not supported
  a_len_zero: assert property (@(posedge axi_aclk) disable iff (!sys_rstn)
    (capture_wr_o || capture_rd_o) |=> len_zero_i);

endmodule

// ==== hw/ack_timer.sv ====
// Acknowledge watchdog. Times out ACK_TIMEOUT cycles after start unless ack_i arrives first.
`timescale 1ns/1ps

module ack_timer (
  input  logic axi_aclk,
  input  logic sys_rstn,
  input  logic start_i,
  input  logic ack_i,
  output logic timeout_o
);

  logic [axi_sys_pkg::ACK_CNT_W-1:0] cnt_q;
  logic                              run_q;
  logic                              timeout_q;

  always_ff @(posedge axi_aclk) begin
    if (!sys_rstn) begin
      cnt_q     <= '0;
      run_q     <= 1'b0;
      timeout_q <= 1'b0;
    end else begin
      timeout_q <= 1'b0;
      if (start_i) begin
        cnt_q <= '0;
        run_q <= !ack_i;  // ack in the pulse cycle
      end else if (run_q) begin
        if (ack_i) begin
          run_q <= 1'b0;
        end else if (cnt_q == axi_sys_pkg::ACK_CNT_W'(axi_sys_pkg::ACK_TIMEOUT - 1)) begin
          run_q     <= 1'b0;
          timeout_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign timeout_o = timeout_q;

  // a slave must not answer in the very cycle the bridge gives up
  a_no_late_ack: assert property (@(posedge axi_aclk) disable iff (!sys_rstn)
    !(timeout_o && ack_i));

endmodule

// ==== hw/axi_bridge_datapath.sv ====
// Bridge payload registers. Address, data and strobes stay stable until the next capture.
// Reads drive all byte selects; read data is forced to zero on any error response.
`timescale 1ns/1ps

module axi_bridge_datapath (
  input  logic                           axi_aclk,
  input  logic                           sys_rstn,
  input  logic [axi_sys_pkg::AXI_IW-1:0] awid_i,
  input  logic [axi_sys_pkg::AXI_AW-1:0] awaddr_i,
  input  logic [axi_sys_pkg::AXI_LW-1:0] awlen_i,
  input  logic [axi_sys_pkg::AXI_ZW-1:0] awsize_i,
  input  logic [axi_sys_pkg::AXI_DW-1:0] wdata_i,
  input  logic [axi_sys_pkg::AXI_SW-1:0] wstrb_i,
  input  logic [axi_sys_pkg::AXI_IW-1:0] arid_i,
  input  logic [axi_sys_pkg::AXI_AW-1:0] araddr_i,
  input  logic [axi_sys_pkg::AXI_LW-1:0] arlen_i,
  input  logic [axi_sys_pkg::AXI_ZW-1:0] arsize_i,
  input  logic                           capture_wr_i,
  input  logic                           capture_rd_i,
  input  logic                           issue_wen_i,
  input  logic                           issue_ren_i,
  input  logic                           resp_load_i,
  input  axi_sys_pkg::resp_e             resp_sel_i,
  input  logic [axi_sys_pkg::AXI_DW-1:0] sys_rdata_i,
  output logic                           size_ok_o,
  output logic                           len_zero_o,
  output logic [axi_sys_pkg::AXI_AW-1:0] sys_addr_o,
  output logic [axi_sys_pkg::AXI_DW-1:0] sys_wdata_o,
  output logic [axi_sys_pkg::AXI_SW-1:0] sys_sel_o,
  output logic                           sys_wen_o,
  output logic                           sys_ren_o,
  output logic [axi_sys_pkg::AXI_IW-1:0] bid_o,
  output logic [1:0]                     bresp_o,
  output logic [axi_sys_pkg::AXI_IW-1:0] rid_o,
  output logic [axi_sys_pkg::AXI_DW-1:0] rdata_o,
  output logic [1:0]                     rresp_o
);

  logic [axi_sys_pkg::AXI_IW-1:0] id_q;
  logic [axi_sys_pkg::AXI_AW-1:0] addr_q;
  logic [axi_sys_pkg::AXI_DW-1:0] wdata_q;
  logic [axi_sys_pkg::AXI_SW-1:0] strb_q;
  logic [axi_sys_pkg::AXI_ZW-1:0] size_q;
  logic [axi_sys_pkg::AXI_LW-1:0] len_q;
  logic [axi_sys_pkg::AXI_DW-1:0] rdata_q;
  axi_sys_pkg::resp_e             resp_q;

  // ------------------------------
  // request capture
  // ------------------------------
  always_ff @(posedge axi_aclk) begin
    if (capture_wr_i) begin
      id_q    <= awid_i;
      addr_q  <= awaddr_i;
      wdata_q <= wdata_i;
      strb_q  <= wstrb_i;
      size_q  <= awsize_i;
      len_q   <= awlen_i;
    end else if (capture_rd_i) begin
      id_q   <= arid_i;
      addr_q <= araddr_i;
      strb_q <= '1;  // full word on reads
      size_q <= arsize_i;
      len_q  <= arlen_i;
    end
  end

  assign size_ok_o  = (size_q == axi_sys_pkg::AXI_SIZE_WORD);
  assign len_zero_o = (len_q == '0);

  assign sys_addr_o  = addr_q;
  assign sys_wdata_o = wdata_q;
  assign sys_sel_o   = strb_q;
  assign sys_wen_o   = issue_wen_i;
  assign sys_ren_o   = issue_ren_i;

  // ------------------------------
  // response hold
  // ------------------------------
  always_ff @(posedge axi_aclk) begin
    if (!sys_rstn) resp_q <= axi_sys_pkg::RESP_OKAY;
    else if (resp_load_i) resp_q <= resp_sel_i;
  end

  always_ff @(posedge axi_aclk) begin
    if (resp_load_i) begin
      rdata_q <= (resp_sel_i == axi_sys_pkg::RESP_OKAY) ? sys_rdata_i : '0;
    end
  end

  assign bid_o   = id_q;
  assign rid_o   = id_q;
  assign bresp_o = resp_q;
  assign rresp_o = resp_q;
  assign rdata_o = rdata_q;

endmodule

// ==== hw/sys_reg_bank.sv ====
// Small system bus peripheral. Only address bits 9:0 are decoded; unmapped offsets never ack.
// Register B acks REG_B_ACK_DLY cycles late; a write to the ID register returns an error.
`timescale 1ns/1ps

module sys_reg_bank (
  input  logic                           axi_aclk,
  input  logic                           sys_rstn,
  input  logic [axi_sys_pkg::AXI_AW-1:0] sys_addr_i,
  input  logic [axi_sys_pkg::AXI_DW-1:0] sys_wdata_i,
  input  logic [axi_sys_pkg::AXI_SW-1:0] sys_sel_i,
  input  logic                           sys_wen_i,
  input  logic                           sys_ren_i,
  output logic [axi_sys_pkg::AXI_DW-1:0] sys_rdata_o,
  output logic                           sys_ack_o,
  output logic                           sys_err_o
);

  logic [axi_sys_pkg::AXI_DW-1:0]        reg_a;
  logic [axi_sys_pkg::AXI_DW-1:0]        reg_b;
  logic [axi_sys_pkg::AXI_DW-1:0]        reg_c;
  logic [axi_sys_pkg::REG_B_ACK_DLY-1:0] b_dly;  // ack delay line for B
  logic hit_a, hit_b, hit_c, hit_id;
  logic req;

  assign hit_a  = (sys_addr_i[9:0] == axi_sys_pkg::REG_A_OFS);
  assign hit_b  = (sys_addr_i[9:0] == axi_sys_pkg::REG_B_OFS);
  assign hit_c  = (sys_addr_i[9:0] == axi_sys_pkg::REG_C_OFS);
  assign hit_id = (sys_addr_i[9:0] == axi_sys_pkg::REG_ID_OFS);
  assign req    = sys_wen_i || sys_ren_i;

  always_ff @(posedge axi_aclk) begin
    if (!sys_rstn) begin
      reg_a <= '0;
      reg_b <= axi_sys_pkg::REG_B_RST;
      reg_c <= axi_sys_pkg::REG_C_RST;
      b_dly <= '0;
    end else begin
      b_dly <= {b_dly[axi_sys_pkg::REG_B_ACK_DLY-2:0], req && hit_b};
      for (int i = 0; i < axi_sys_pkg::AXI_SW; i++) begin
        if (sys_wen_i && sys_sel_i[i]) begin  // byte lanes
          if (hit_a) reg_a[8*i +: 8] <= sys_wdata_i[8*i +: 8];
          if (hit_b) reg_b[8*i +: 8] <= sys_wdata_i[8*i +: 8];
          if (hit_c) reg_c[8*i +: 8] <= sys_wdata_i[8*i +: 8];
        end
      end
    end
  end

  // ------------------------------
  // read mux and acknowledge
  // ------------------------------
  always_comb begin
    sys_rdata_o = '0;
    sys_ack_o   = 1'b0;
    sys_err_o   = 1'b0;
    if (hit_a) begin
      sys_rdata_o = reg_a;
      sys_ack_o   = req;
    end else if (hit_b) begin
      sys_rdata_o = reg_b;
      sys_ack_o   = b_dly[axi_sys_pkg::REG_B_ACK_DLY-1];
    end else if (hit_c) begin
      sys_rdata_o = reg_c;
      sys_ack_o   = req;
    end else if (hit_id) begin
      sys_rdata_o = axi_sys_pkg::REG_ID_VAL;
      sys_ack_o   = req;
      sys_err_o   = sys_wen_i;  // read-only
    end
  end

endmodule

// ==== hw/axi_sys_top.sv ====
// AXI slave to system bus bridge with the register bank attached.
// Single-beat accesses only; AWLEN/ARLEN must be 0 and WLAST high.
`timescale 1ns/1ps

module axi_sys_top (
  input  logic                           axi_aclk,
  input  logic                           sys_rstn,
  // write address
  input  logic [axi_sys_pkg::AXI_IW-1:0] awid_i,
  input  logic [axi_sys_pkg::AXI_AW-1:0] awaddr_i,
  input  logic [axi_sys_pkg::AXI_LW-1:0] awlen_i,
  input  logic [axi_sys_pkg::AXI_ZW-1:0] awsize_i,
  input  logic                           awvalid_i,
  output logic                           awready_o,
  // write data
  input  logic [axi_sys_pkg::AXI_DW-1:0] wdata_i,
  input  logic [axi_sys_pkg::AXI_SW-1:0] wstrb_i,
  input  logic                           wlast_i,
  input  logic                           wvalid_i,
  output logic                           wready_o,
  // write response
  output logic [axi_sys_pkg::AXI_IW-1:0] bid_o,
  output logic [1:0]                     bresp_o,
  output logic                           bvalid_o,
  input  logic                           bready_i,
  // read address
  input  logic [axi_sys_pkg::AXI_IW-1:0] arid_i,
  input  logic [axi_sys_pkg::AXI_AW-1:0] araddr_i,
  input  logic [axi_sys_pkg::AXI_LW-1:0] arlen_i,
  input  logic [axi_sys_pkg::AXI_ZW-1:0] arsize_i,
  input  logic                           arvalid_i,
  output logic                           arready_o,
  // read data
  output logic [axi_sys_pkg::AXI_IW-1:0] rid_o,
  output logic [axi_sys_pkg::AXI_DW-1:0] rdata_o,
  output logic [1:0]                     rresp_o,
  output logic                           rlast_o,
  output logic                           rvalid_o,
  input  logic                           rready_i
);

  logic size_ok, len_zero, timeout, timer_start;
  logic capture_wr, capture_rd, issue_wen, issue_ren, resp_load;
  axi_sys_pkg::resp_e resp_sel;

  // system bus
  logic [axi_sys_pkg::AXI_AW-1:0] sys_addr;
  logic [axi_sys_pkg::AXI_DW-1:0] sys_wdata;
  logic [axi_sys_pkg::AXI_SW-1:0] sys_sel;
  logic [axi_sys_pkg::AXI_DW-1:0] sys_rdata;
  logic sys_wen, sys_ren, sys_ack, sys_err;

  axi_req_fsm u_axi_req_fsm (
    .axi_aclk     (axi_aclk),     .sys_rstn     (sys_rstn),
    .awvalid_i    (awvalid_i),    .wvalid_i     (wvalid_i),
    .arvalid_i    (arvalid_i),    .bready_i     (bready_i),
    .rready_i     (rready_i),     .size_ok_i    (size_ok),
    .len_zero_i   (len_zero),     .sys_ack_i    (sys_ack),
    .sys_err_i    (sys_err),      .timeout_i    (timeout),
    .awready_o    (awready_o),    .wready_o     (wready_o),
    .arready_o    (arready_o),    .bvalid_o     (bvalid_o),
    .rvalid_o     (rvalid_o),     .capture_wr_o (capture_wr),
    .capture_rd_o (capture_rd),   .issue_wen_o  (issue_wen),
    .issue_ren_o  (issue_ren),    .timer_start_o(timer_start),
    .resp_load_o  (resp_load),    .resp_sel_o   (resp_sel)
  );

  ack_timer u_ack_timer (
    .axi_aclk (axi_aclk),
    .sys_rstn (sys_rstn),
    .start_i  (timer_start),
    .ack_i    (sys_ack),
    .timeout_o(timeout)
  );

  axi_bridge_datapath u_axi_bridge_datapath (
    .axi_aclk    (axi_aclk),    .sys_rstn    (sys_rstn),
    .awid_i      (awid_i),      .awaddr_i    (awaddr_i),
    .awlen_i     (awlen_i),     .awsize_i    (awsize_i),
    .wdata_i     (wdata_i),     .wstrb_i     (wstrb_i),
    .arid_i      (arid_i),      .araddr_i    (araddr_i),
    .arlen_i     (arlen_i),     .arsize_i    (arsize_i),
    .capture_wr_i(capture_wr),  .capture_rd_i(capture_rd),
    .issue_wen_i (issue_wen),   .issue_ren_i (issue_ren),
    .resp_load_i (resp_load),   .resp_sel_i  (resp_sel),
    .sys_rdata_i (sys_rdata),   .size_ok_o   (size_ok),
    .len_zero_o  (len_zero),    .sys_addr_o  (sys_addr),
    .sys_wdata_o (sys_wdata),   .sys_sel_o   (sys_sel),
    .sys_wen_o   (sys_wen),     .sys_ren_o   (sys_ren),
    .bid_o       (bid_o),       .bresp_o     (bresp_o),
    .rid_o       (rid_o),       .rdata_o     (rdata_o),
    .rresp_o     (rresp_o)
  );

  sys_reg_bank u_sys_reg_bank (
    .axi_aclk   (axi_aclk),
    .sys_rstn   (sys_rstn),
    .sys_addr_i (sys_addr),
    .sys_wdata_i(sys_wdata),
    .sys_sel_i  (sys_sel),
    .sys_wen_i  (sys_wen),
    .sys_ren_i  (sys_ren),
    .sys_rdata_o(sys_rdata),
    .sys_ack_o  (sys_ack),
    .sys_err_o  (sys_err)
  );

  assign rlast_o = rvalid_o;  // single beat

  // every accepted write beat must be the last one
  a_wlast: assert property (@(posedge axi_aclk) disable iff (!sys_rstn)
    (wvalid_i && wready_o) |-> wlast_i);

endmodule

// ==== tb/axi_sys_tb.sv ====
// Testbench for the AXI bridge with its register bank. Inputs change on the falling edge,
// responses are sampled on the rising edge and checked in the order requests were accepted.
`timescale 1ns/1ps

module axi_sys_tb;

  localparam int CLK_HALF   = 20;  // 40 ns period
  localparam int N_ACCESSES = 240;
  localparam int WD_CYCLES  = N_ACCESSES * (axi_sys_pkg::ACK_TIMEOUT + 20);

  logic                           axi_aclk;
  logic                           sys_rstn;
  logic [axi_sys_pkg::AXI_IW-1:0] awid, arid, bid, rid;
  logic [31:0]                    awaddr, araddr, wdata, rdata;
  logic [3:0]                     awlen, arlen, wstrb;
  logic [2:0]                     awsize, arsize;
  logic [1:0]                     bresp, rresp;
  logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rlast, rvalid, rready;

  logic [31:0] reg_model [4];  // A, B, C, ID by word slot
  logic [31:0] exp_bid [$];
  logic [31:0] exp_bresp [$];
  logic [31:0] exp_rid [$];
  logic [31:0] exp_rresp [$];
  logic [31:0] exp_rdata [$];
  logic        b_hold, r_hold;
  logic [31:0] b_hold_id, b_hold_resp, r_hold_id, r_hold_resp, r_hold_data;
  int          errors = 0;
  int          checks = 0;

  axi_sys_top u_axi_sys_top (
    .axi_aclk (axi_aclk), .sys_rstn (sys_rstn),
    .awid_i   (awid),     .awaddr_i (awaddr),  .awlen_i  (awlen),  .awsize_i (awsize),
    .awvalid_i(awvalid),  .awready_o(awready),
    .wdata_i  (wdata),    .wstrb_i  (wstrb),   .wlast_i  (wlast),
    .wvalid_i (wvalid),   .wready_o (wready),
    .bid_o    (bid),      .bresp_o  (bresp),   .bvalid_o (bvalid), .bready_i (bready),
    .arid_i   (arid),     .araddr_i (araddr),  .arlen_i  (arlen),  .arsize_i (arsize),
    .arvalid_i(arvalid),  .arready_o(arready),
    .rid_o    (rid),      .rdata_o  (rdata),   .rresp_o  (rresp),  .rlast_o  (rlast),
    .rvalid_o (rvalid),   .rready_i (rready)
  );

  initial begin
    axi_aclk = 1'b0;
    forever #CLK_HALF axi_aclk = ~axi_aclk;
  end

  // ------------------------------
  // reference model and checker
  // ------------------------------
  function automatic logic [1:0] ref_access(input logic is_wr, input logic [31:0] addr,
      input logic [2:0] size, input logic [31:0] wdata_v, input logic [3:0] strb,
      output logic [31:0] exp_data);
    logic [9:0]  ofs;
    logic [1:0]  idx;
    logic [31:0] mask;
    ofs      = addr[9:0];
    idx      = ofs[3:2];  // map offsets are word slots 0 to 3
    mask     = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    exp_data = '0;
    if (size != axi_sys_pkg::AXI_SIZE_WORD) return axi_sys_pkg::RESP_SLVERR;
    if (ofs != axi_sys_pkg::REG_A_OFS && ofs != axi_sys_pkg::REG_B_OFS &&
        ofs != axi_sys_pkg::REG_C_OFS && ofs != axi_sys_pkg::REG_ID_OFS) begin
      return axi_sys_pkg::RESP_DECERR;  // no ack, timer expires
    end
    if (is_wr) begin
      if (ofs == axi_sys_pkg::REG_ID_OFS) return axi_sys_pkg::RESP_SLVERR;
      reg_model[idx] = (reg_model[idx] & ~mask) | (wdata_v & mask);
    end else begin
      exp_data = reg_model[idx];
    end
    return axi_sys_pkg::RESP_OKAY;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t",
               name, got, expected, $time);
    end
  endtask

  always @(posedge axi_aclk) begin
    if (!sys_rstn) begin
      b_hold = 1'b0;
      r_hold = 1'b0;
    end else begin
      if (b_hold) begin  // stalled last cycle
        check_val("bvalid", 32'(bvalid), 32'd1);
        check_val("bid", 32'(bid), b_hold_id);
        check_val("bresp", 32'(bresp), b_hold_resp);
      end
      if (r_hold) begin
        check_val("rvalid", 32'(rvalid), 32'd1);
        check_val("rid", 32'(rid), r_hold_id);
        check_val("rresp", 32'(rresp), r_hold_resp);
        check_val("rdata", rdata, r_hold_data);
      end
      if (bvalid || rvalid) begin  // nothing accepted while a response waits
        check_val("awready", 32'(awready), 32'd0);
        check_val("wready", 32'(wready), 32'd0);
        check_val("arready", 32'(arready), 32'd0);
      end
      if (bvalid && bready) begin
        if (exp_bid.size() == 0) begin
          errors++;
          $display("write response seen with no accepted write at %0t", $time);
        end else begin
          check_val("bid", 32'(bid), exp_bid.pop_front());
          check_val("bresp", 32'(bresp), exp_bresp.pop_front());
        end
      end
      if (rvalid && rready) begin
        if (exp_rid.size() == 0) begin
          errors++;
          $display("read response seen with no accepted read at %0t", $time);
        end else begin
          check_val("rid", 32'(rid), exp_rid.pop_front());
          check_val("rresp", 32'(rresp), exp_rresp.pop_front());
          check_val("rdata", rdata, exp_rdata.pop_front());
          check_val("rlast", 32'(rlast), 32'd1);
        end
      end
      b_hold      = bvalid && !bready;
      b_hold_id   = 32'(bid);
      b_hold_resp = 32'(bresp);
      r_hold      = rvalid && !rready;
      r_hold_id   = 32'(rid);
      r_hold_resp = 32'(rresp);
      r_hold_data = rdata;
    end
  end

  // ------------------------------
  // master tasks
  // ------------------------------
  task automatic axi_write(input logic [axi_sys_pkg::AXI_IW-1:0] id, input logic [31:0] addr,
                           input logic [2:0] size, input logic [31:0] data,
                           input logic [3:0] strb, input int bp);
    logic [31:0] rd_unused;
    logic [1:0]  resp;
    @(negedge axi_aclk);
    awid    = id;
    awaddr  = addr;
    awsize  = size;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do @(posedge axi_aclk); while (!awready);
    check_val("wready", 32'(wready), 32'd1);  // data taken with the address
    resp = ref_access(1'b1, addr, size, data, strb, rd_unused);
    exp_bid.push_back(32'(id));
    exp_bresp.push_back(32'(resp));
    @(negedge axi_aclk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = (bp == 0);
    do @(posedge axi_aclk); while (!bvalid);
    if (bp != 0) begin  // stall the response
      repeat (bp - 1) @(posedge axi_aclk);
      @(negedge axi_aclk);
      bready = 1'b1;
      @(posedge axi_aclk);
    end
    @(negedge axi_aclk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [axi_sys_pkg::AXI_IW-1:0] id, input logic [31:0] addr,
                          input logic [2:0] size, input int bp);
    logic [31:0] data;
    logic [1:0]  resp;
    @(negedge axi_aclk);
    arid    = id;
    araddr  = addr;
    arsize  = size;
    arvalid = 1'b1;
    do @(posedge axi_aclk); while (!arready);
    resp = ref_access(1'b0, addr, size, 32'h0, 4'h0, data);
    exp_rid.push_back(32'(id));
    exp_rresp.push_back(32'(resp));
    exp_rdata.push_back(data);
    @(negedge axi_aclk);
    arvalid = 1'b0;
    rready  = (bp == 0);
    do @(posedge axi_aclk); while (!rvalid);
    if (bp != 0) begin
      repeat (bp - 1) @(posedge axi_aclk);
      @(negedge axi_aclk);
      rready = 1'b1;
      @(posedge axi_aclk);
    end
    @(negedge axi_aclk);
    rready = 1'b0;
  endtask

  initial begin
    int          seed_ret;
    int          k;
    int          kind;
    logic [31:0] rnd;
    logic [9:0]  ofs;
    logic [2:0]  size;
    seed_ret     = $urandom(32'hc9fa);
    reg_model[0] = '0;
    reg_model[1] = axi_sys_pkg::REG_B_RST;
    reg_model[2] = axi_sys_pkg::REG_C_RST;
    reg_model[3] = axi_sys_pkg::REG_ID_VAL;
    sys_rstn = 1'b0;
    awid     = '0;
    awaddr   = '0;
    awlen    = '0;
    awsize   = 3'd2;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wlast    = 1'b1;  // single beat only
    wvalid   = 1'b0;
    bready   = 1'b0;
    arid     = '0;
    araddr   = '0;
    arlen    = '0;
    arsize   = 3'd2;
    arvalid  = 1'b0;
    rready   = 1'b0;
    repeat (2) @(posedge axi_aclk);
    @(negedge axi_aclk);
    sys_rstn = 1'b1;

    // reset values
    axi_read(12'h011, 32'h0, 3'd2, 0);
    axi_read(12'h022, 32'h4, 3'd2, 0);
    axi_read(12'h033, 32'h8, 3'd2, 0);
    axi_read(12'h044, 32'hc, 3'd2, 0);
    // full and partial strobes, B acks late
    axi_write(12'h101, 32'h0, 3'd2, 32'hdead_beef, 4'hf, 0);
    axi_write(12'h102, 32'h0, 3'd2, 32'h1122_3344, 4'b0110, 0);
    axi_write(12'h103, 32'h4, 3'd2, 32'haabb_ccdd, 4'b0101, 0);
    axi_write(12'h104, 32'h8, 3'd2, 32'h5a00_0000, 4'b1000, 1);
    axi_read(12'h105, 32'h0, 3'd2, 0);
    axi_read(12'h106, 32'h4, 3'd2, 0);
    axi_read(12'h107, 32'h8, 3'd2, 0);
    // halfword size is refused
    axi_write(12'h201, 32'h8, 3'd1, 32'hffff_ffff, 4'hf, 0);
    axi_read(12'h202, 32'h4, 3'd1, 0);
    axi_read(12'h203, 32'h8, 3'd2, 0);
    // unmapped offsets and the read-only ID
    axi_write(12'h301, 32'h14, 3'd2, 32'h0123_4567, 4'hf, 0);
    axi_read(12'h302, 32'h20, 3'd2, 0);
    axi_write(12'h303, 32'hc, 3'd2, 32'h0, 4'hf, 0);
    axi_read(12'h304, 32'hc, 3'd2, 0);

    // ------------------------------
    // back-pressure with a competing request
    // ------------------------------
    for (k = 0; k < 4; k++) begin
      fork
        axi_write(12'($urandom), 32'h4, 3'd2, $urandom, 4'hf, $urandom_range(2, 8));
        begin
          repeat (2) @(negedge axi_aclk);
          axi_read(12'($urandom), 32'h4, 3'd2, $urandom_range(2, 8));
        end
      join
      fork
        axi_read(12'($urandom), 32'h0, 3'd2, $urandom_range(2, 8));
        axi_write(12'($urandom), 32'h0, 3'd2, $urandom, 4'($urandom), 0);
      join
    end

    for (k = 0; k < 200; k++) begin
      rnd  = $urandom;
      kind = $urandom_range(0, 3);
      size = ($urandom_range(0, 9) == 0) ? 3'd1 : 3'd2;  // occasional bad size
      case (kind)
        0:       ofs = axi_sys_pkg::REG_A_OFS;
        1:       ofs = axi_sys_pkg::REG_B_OFS;
        2:       ofs = axi_sys_pkg::REG_C_OFS;
        default: ofs = axi_sys_pkg::REG_ID_OFS;
      endcase
      if ($urandom_range(0, 1) == 1) begin
        axi_write(12'($urandom), {rnd[31:10], ofs}, size, $urandom, 4'($urandom),
                  $urandom_range(0, 3));
      end else begin
        axi_read(12'($urandom), {rnd[31:10], ofs}, size, $urandom_range(0, 3));
      end
    end

    repeat (4) @(negedge axi_aclk);
    if (exp_bid.size() != 0 || exp_rid.size() != 0) begin
      errors++;
      $display("responses missing: %0d write and %0d read never completed",
               exp_bid.size(), exp_rid.size());
    end
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge axi_aclk);
    $display("watchdog expired after %0d cycles, the run did not complete", WD_CYCLES);
    $display("checks: %0d errors: %0d", checks, errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== build.f ====
hw/axi_sys_pkg.sv
hw/axi_req_fsm.sv
hw/ack_timer.sv
hw/axi_bridge_datapath.sv
hw/sys_reg_bank.sv
hw/axi_sys_top.sv
tb/axi_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the bridge testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=axi_sys_sim
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module axi_sys_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  echo "run ok, see $LOG"
  exit 0
else
  echo "run failed, see $LOG"
  exit 1
fi
